/* Makefile */
# Verilator build and run of the dot-product engine testbench

VERILATOR ?= verilator
TOP       ?= tb_dot_engine
FILELIST  ?= lstm_dot.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/adder_tree.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_cfg.svh"

module adder_tree
	import fixed_pkg::*, stream_pkg::*;
(
	input  wire  clk,
	input  wire  reset,
	input  wire  prod_valid,
	input  wire  lane_vec_t prod_vec,
	input  wire  tag_t prod_tag,
	output logic sum_valid,
	output fix_t sum,
	output tag_t sum_tag
);

	localparam int LEVELS = $clog2(`DOT_LANES);
	localparam int MID    = LEVELS / 2;          // register bank after this level
	localparam int MID_N  = `DOT_LANES >> MID;   // partial sums held there

	fix_t mid_q [MID_N];
	logic mid_valid;
	tag_t mid_tag;

	// level 0 is the lane products, level LEVELS the full sum
	for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
		fix_t node [`DOT_LANES >> l];

		if (l == 0) begin : g_in
			for (genvar j = 0; j < `DOT_LANES; j++) begin : g_node
				assign node[j] = prod_vec[j*`DOT_DATA_WIDTH +: `DOT_DATA_WIDTH];
			end
		end else if (l == MID + 1) begin : g_from_reg
			for (genvar j = 0; j < (`DOT_LANES >> l); j++) begin : g_node
				assign node[j] = mid_q[2*j] + mid_q[2*j+1];
			end
		end else begin : g_add
			for (genvar j = 0; j < (`DOT_LANES >> l); j++) begin : g_node
				assign node[j] = g_lvl[l-1].node[2*j] + g_lvl[l-1].node[2*j+1];
			end
		end
	end

	// adds wrap at 16 bits, so pairing order does not change the sum
	always_ff @(posedge clk) begin
		for (int k = 0; k < MID_N; k++) begin
			mid_q[k] <= g_lvl[MID].node[k];
		end
	end

	always_ff @(posedge clk) begin
		if (prod_valid)
			mid_tag <= prod_tag;
		if (mid_valid)
			sum_tag <= mid_tag;
		sum <= g_lvl[LEVELS].node[0];
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			mid_valid <= 1'b0;
			sum_valid <= 1'b0;
		end else begin
			mid_valid <= prod_valid;
			sum_valid <= mid_valid;
		end
	end

endmodule

`default_nettype wire

/* design/dot_cfg.svh */
`ifndef DOT_CFG_SVH
`define DOT_CFG_SVH

// lanes per transfer, a power of two from 2 to 64
`define DOT_LANES 16

// signed fixed point, 3 integer bits and 12 fraction bits
`define DOT_DATA_WIDTH 16
`define DOT_FRAC_BITS 12

`define DOT_TAG_WIDTH 8

// credits held upstream after reset, same as the result buffer depth
`define DOT_CREDITS 8

`endif

/* design/dot_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dot_engine
	import fixed_pkg::*, stream_pkg::*;
(
	input  wire  clk,
	input  wire  reset,
	input  wire  in_valid,
	input  wire  lane_vec_t in_vector,
	input  wire  lane_vec_t in_weight,
	input  wire  tag_t in_tag,
	output logic in_credit,
	output logic out_valid,
	output fix_t out_sum,
	output tag_t out_tag,
	input  wire  out_ready
);

	logic      prod_valid;
	lane_vec_t prod_vec;
	tag_t      prod_tag;

	logic sum_valid;
	fix_t sum;
	tag_t sum_tag;

	lane_mul_array u_mul (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_vector  (in_vector),
		.in_weight  (in_weight),
		.in_tag     (in_tag),
		.prod_valid (prod_valid),
		.prod_vec   (prod_vec),
		.prod_tag   (prod_tag)
	);

	adder_tree u_tree (
		.clk        (clk),
		.reset      (reset),
		.prod_valid (prod_valid),
		.prod_vec   (prod_vec),
		.prod_tag   (prod_tag),
		.sum_valid  (sum_valid),
		.sum        (sum),
		.sum_tag    (sum_tag)
	);

	// credits go back as results leave
	result_fifo u_fifo (
		.clk       (clk),
		.reset     (reset),
		.sum_valid (sum_valid),
		.sum       (sum),
		.sum_tag   (sum_tag),
		.out_valid (out_valid),
		.out_sum   (out_sum),
		.out_tag   (out_tag),
		.out_ready (out_ready),
		.in_credit (in_credit)
	);

endmodule

`default_nettype wire

/* design/fixed_pkg.sv */
`default_nettype none

`include "dot_cfg.svh"

package fixed_pkg;

	// one lane operand, lane product or sum
	typedef logic signed [`DOT_DATA_WIDTH-1:0] fix_t;

	// full product of two magnitudes
	typedef logic [2*`DOT_DATA_WIDTH-1:0] mag_prod_t;

	// lane 0 sits in the low bits
	typedef logic [`DOT_LANES*`DOT_DATA_WIDTH-1:0] lane_vec_t;

endpackage

`default_nettype wire

/* design/lane_mul_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_cfg.svh"

module lane_mul_array
	import fixed_pkg::*, stream_pkg::*;
(
	input  wire       clk,
	input  wire       reset,
	input  wire       in_valid,
	input  wire       lane_vec_t in_vector,
	input  wire       lane_vec_t in_weight,
	input  wire       tag_t in_tag,
	output logic      prod_valid,
	output wire       lane_vec_t prod_vec,
	output tag_t      prod_tag
);

	lane_vec_t vec_q;
	lane_vec_t wgt_q;
	tag_t      tag_q;
	logic      valid_q;

	// operands only load on an accepted transfer
	always_ff @(posedge clk) begin
		if (in_valid) begin
			vec_q <= in_vector;
			wgt_q <= in_weight;
			tag_q <= in_tag;
		end
	end

	// tag follows the multiplier output register
	always_ff @(posedge clk) begin
		if (valid_q)
			prod_tag <= tag_q;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			valid_q    <= 1'b0;
			prod_valid <= 1'b0;
		end else begin
			valid_q    <= in_valid;
			prod_valid <= valid_q;
		end
	end

	for (genvar i = 0; i < `DOT_LANES; i++) begin : g_lane
		signed_mul u_mul (
			.clk (clk),
			.a   (vec_q[i*`DOT_DATA_WIDTH +: `DOT_DATA_WIDTH]),
			.b   (wgt_q[i*`DOT_DATA_WIDTH +: `DOT_DATA_WIDTH]),
			.c   (prod_vec[i*`DOT_DATA_WIDTH +: `DOT_DATA_WIDTH])
		);
	end

endmodule

`default_nettype wire

/* design/result_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_cfg.svh"

module result_fifo
	import fixed_pkg::*, stream_pkg::*;
(
	input  wire  clk,
	input  wire  reset,
	input  wire  sum_valid,
	input  wire  fix_t sum,
	input  wire  tag_t sum_tag,
	output logic out_valid,
	output fix_t out_sum,
	output tag_t out_tag,
	input  wire  out_ready,
	output logic in_credit
);

	localparam int DEPTH = `DOT_CREDITS;   // power of two
	localparam int AW    = $clog2(DEPTH);

	fix_t sum_mem [DEPTH];
	tag_t tag_mem [DEPTH];

	fifo_ptr_t wr_ptr;
	fifo_ptr_t rd_ptr;
	logic      pop;

	// pointers differ in wrap bit only when full
	assign out_valid = (wr_ptr != rd_ptr);
	assign pop       = out_valid && out_ready;

	// head entry shown directly, steady until popped
	assign out_sum = sum_mem[rd_ptr[AW-1:0]];
	assign out_tag = tag_mem[rd_ptr[AW-1:0]];

	// no full check, the upstream never holds more credits than slots
	always_ff @(posedge clk) begin
		if (sum_valid) begin
			sum_mem[wr_ptr[AW-1:0]] <= sum;
			tag_mem[wr_ptr[AW-1:0]] <= sum_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			in_credit <= 1'b0;
		end else begin
			if (sum_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			in_credit <= pop; // slot freed, one credit back
		end
	end

endmodule

`default_nettype wire

/* design/signed_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_cfg.svh"

module signed_mul
	import fixed_pkg::*;
(
	input  wire  clk,
	input  wire  fix_t a,
	input  wire  fix_t b,
	output fix_t c
);

	// top product bit kept, one below the sign position of the result
	localparam int KEEP_MSB = `DOT_FRAC_BITS + `DOT_DATA_WIDTH - 2;

	logic [`DOT_DATA_WIDTH-1:0] a_mag;
	logic [`DOT_DATA_WIDTH-1:0] b_mag;
	mag_prod_t mag_prod;
	fix_t      kept;
	logic      neg;

	// -32768 stays 0x8000 here, read as unsigned below
	assign a_mag = a[`DOT_DATA_WIDTH-1] ? -a : a;
	assign b_mag = b[`DOT_DATA_WIDTH-1] ? -b : b;

	assign mag_prod = a_mag * b_mag;

	// drop fraction bits by truncation
	assign kept = {1'b0, mag_prod[KEEP_MSB:`DOT_FRAC_BITS]};

	assign neg = a[`DOT_DATA_WIDTH-1] ^ b[`DOT_DATA_WIDTH-1];

	always_ff @(posedge clk) begin
		if (neg)
			c <= -kept;
		else
			c <= kept;
	end

endmodule

`default_nettype wire

/* design/stream_pkg.sv */
`default_nettype none

`include "dot_cfg.svh"

package stream_pkg;

	typedef logic [`DOT_TAG_WIDTH-1:0] tag_t; // matched by the upstream

	// buffer index plus a wrap bit for full vs empty
	typedef logic [$clog2(`DOT_CREDITS):0] fifo_ptr_t;

endpackage

`default_nettype wire

/* lstm_dot.f */
+incdir+design
design/fixed_pkg.sv
design/stream_pkg.sv
design/signed_mul.sv
design/lane_mul_array.sv
design/adder_tree.sv
design/result_fifo.sv
design/dot_engine.sv
test/tb_dot_engine.sv

/* test/tb_dot_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dot_cfg.svh"

module tb_dot_engine
	import fixed_pkg::*, stream_pkg::*;
();

	localparam int W               = `DOT_DATA_WIDTH;
	localparam int FRAC            = `DOT_FRAC_BITS;
	localparam int LANES           = `DOT_LANES;
	localparam int CREDITS         = `DOT_CREDITS;
	localparam int RESET_CYCLES    = 8;
	localparam int PIPE_LATENCY    = 4;
	localparam int N_DIRECTED      = 11;
	localparam int N_STREAM        = 200;
	localparam int N_TOTAL         = N_DIRECTED + N_STREAM + CREDITS;
	localparam int IDLE_TIMEOUT    = 200;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_TOTAL * 20 + 1000;

	logic      clk;
	logic      reset;
	logic      in_valid;
	lane_vec_t in_vector;
	lane_vec_t in_weight;
	tag_t      in_tag;
	logic      in_credit;
	logic      out_valid;
	fix_t      out_sum;
	tag_t      out_tag;
	logic      out_ready;

	fix_t        exp_sum [0:511];
	tag_t        exp_tag [0:511];
	int          wr_count;
	int          rd_count;
	int          credits_spent;
	int          credits_returned;
	logic        pop_seen;
	tag_t        next_tag;
	string       test_name;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	dot_engine UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_vector (in_vector),
		.in_weight (in_weight),
		.in_tag    (in_tag),
		.in_credit (in_credit),
		.out_valid (out_valid),
		.out_sum   (out_sum),
		.out_tag   (out_tag),
		.out_ready (out_ready)
	);

	// sign-magnitude multiply, fraction bits cut toward zero
	function automatic fix_t lane_product_model(input fix_t a, input fix_t b);
		longint mag_a;
		longint mag_b;
		longint kept;
		mag_a = (a < 0) ? -longint'(a) : longint'(a); // -32768 gives 32768
		mag_b = (b < 0) ? -longint'(b) : longint'(b);
		kept  = ((mag_a * mag_b) >> FRAC) % (longint'(1) << (W - 1)); // bits 26 to 12
		if ((a < 0) != (b < 0))
			return fix_t'(-kept);
		return fix_t'(kept);
	endfunction

	function automatic fix_t dot_model(input lane_vec_t vec, input lane_vec_t wgt);
		fix_t acc;
		acc = '0;
		for (int i = 0; i < LANES; i++)
			acc = acc + lane_product_model(vec[i*W +: W], wgt[i*W +: W]); // wraps
		return acc;
	endfunction

	function automatic int credits_held();
		return CREDITS + credits_returned - credits_spent;
	endfunction

	function automatic lane_vec_t one_lane(input int lane, input fix_t value);
		lane_vec_t vec;
		vec = '0;
		vec[lane*W +: W] = value;
		return vec;
	endfunction

	function automatic lane_vec_t all_lanes(input fix_t value);
		lane_vec_t vec;
		for (int i = 0; i < LANES; i++)
			vec[i*W +: W] = value;
		return vec;
	endfunction

	function automatic lane_vec_t random_lanes();
		lane_vec_t vec;
		for (int i = 0; i < LANES; i++)
			vec[i*W +: W] = fix_t'($urandom);
		return vec;
	endfunction

	task automatic fail_run();
		$display("TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
		fail_run();
	end

	// upstream side of the credit loop
	always @(posedge clk) begin
		if (!reset) begin
			credits_returned = 0;
			pop_seen         = 1'b0;
		end else begin
			assert (in_credit == pop_seen) else begin
				$display("test %s got a credit pulse that did not follow a result by one cycle",
					test_name);
				fail_run();
			end
			if (in_credit)
				credits_returned = credits_returned + 1;
			pop_seen = out_valid && out_ready;
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			rd_count = 0;
		end else if (out_valid && out_ready) begin
			assert (rd_count < wr_count) else begin
				$display("test %s saw a result with no transfer outstanding", test_name);
				fail_run();
			end
			assert (out_sum == exp_sum[rd_count]) else begin
				$display("ERROR %s: sum expected %h, actual %h",
					test_name, exp_sum[rd_count], out_sum);
				fail_run();
			end
			assert (out_tag == exp_tag[rd_count]) else begin
				$display("ERROR %s: tag expected %h, actual %h",
					test_name, exp_tag[rd_count], out_tag);
				fail_run();
			end
			rd_count = rd_count + 1;
		end
	end

	// waits for a credit, then drives one transfer
	task automatic send_transfer(input lane_vec_t vec, input lane_vec_t wgt, input fix_t expected);
		@(negedge clk);
		while (credits_held() == 0) begin
			@(posedge clk);
			in_valid <= 1'b0;
			@(negedge clk);
		end
		exp_sum[wr_count] = expected;
		exp_tag[wr_count] = next_tag;
		wr_count          = wr_count + 1;
		credits_spent     = credits_spent + 1;
		@(posedge clk);
		in_valid  <= 1'b1;
		in_vector <= vec;
		in_weight <= wgt;
		in_tag    <= next_tag;
		next_tag++;
	endtask

	task automatic end_burst();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic set_ready(input logic value);
		@(posedge clk);
		out_ready <= value;
	endtask

	// all results out and all credits home
	task automatic wait_idle();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (rd_count != wr_count || credits_held() != CREDITS) begin
			@(negedge clk);
			cycles++;
			assert (cycles < IDLE_TIMEOUT) else begin
				$display("test %s timed out waiting for results and credits", test_name);
				fail_run();
			end
		end
	endtask

	task automatic check_idle();
		assert (!out_valid) else begin
			$display("test %s saw out_valid high with nothing sent", test_name);
			fail_run();
		end
		assert (!in_credit) else begin
			$display("test %s saw in_credit high with nothing sent", test_name);
			fail_run();
		end
	endtask

	task automatic test_reset_state();
		test_name = "reset_state";
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			if (i == RESET_CYCLES - 1)
				reset <= 1'b1;
			@(negedge clk);
			check_idle();
		end
		repeat (10) begin
			@(negedge clk);
			check_idle();
		end
	endtask

	task automatic test_fixed_products();
		test_name = "fixed_products";
		set_ready(1'b1);
		// sixteen times 1.0 is 16.0, wraps to zero
		send_transfer(all_lanes(16'h1000), all_lanes(16'h1000), 16'h0000);
		send_transfer(one_lane(5, 16'h1800), one_lane(5, 16'h2000), 16'h3000); // 1.5 x 2.0
		send_transfer(one_lane(0, 16'h0003), one_lane(0, 16'h0800), 16'h0001); // 1.5 lsb
		send_transfer(all_lanes(16'h0001), all_lanes(16'h0FFF), 16'h0000); // under one lsb
		end_burst();
		wait_idle();
	endtask

	task automatic test_sign_handling();
		lane_vec_t vec;
		lane_vec_t wgt;
		test_name = "sign_handling";
		set_ready(1'b1);
		send_transfer(one_lane(0, 16'hF000), one_lane(0, 16'hF000), 16'h1000); // -1.0 x -1.0
		send_transfer(one_lane(3, 16'hF800), one_lane(3, 16'h1000), 16'hF800); // -0.5 x 1.0
		send_transfer(one_lane(7, 16'h8000), one_lane(7, 16'h0800), 16'hC000); // -8.0 x 0.5
		send_transfer(one_lane(9, 16'h8000), one_lane(9, 16'h8000), 16'h0000); // 64.0 lost
		send_transfer(one_lane(2, 16'hFFFD), one_lane(2, 16'h0800), 16'hFFFF); // toward zero
		vec = one_lane(0, 16'hF000) | one_lane(3, 16'hF800);
		wgt = one_lane(0, 16'hF000) | one_lane(3, 16'h1000);
		send_transfer(vec, wgt, 16'h0800);
		// mixed signs on every lane
		for (int i = 0; i < LANES; i++) begin
			vec[i*W +: W] = (i % 2 == 1) ? fix_t'(-(i * 300)) : fix_t'(i * 700);
			wgt[i*W +: W] = (i % 3 == 0) ? fix_t'(i * 97 - 4096) : fix_t'(2048 + i * 131);
		end
		send_transfer(vec, wgt, dot_model(vec, wgt));
		end_burst();
		wait_idle();
	endtask

	task automatic test_streaming();
		lane_vec_t vec;
		lane_vec_t wgt;
		test_name = "streaming";
		set_ready(1'b1);
		for (int n = 0; n < N_STREAM; n++) begin
			vec = random_lanes();
			wgt = random_lanes();
			send_transfer(vec, wgt, dot_model(vec, wgt));
		end
		end_burst();
		wait_idle();
	endtask

	task automatic test_back_pressure();
		lane_vec_t vec;
		lane_vec_t wgt;
		int        pops_before;
		test_name = "back_pressure";
		set_ready(1'b0);
		pops_before = rd_count;
		for (int n = 0; n < CREDITS; n++) begin
			vec = random_lanes();
			wgt = random_lanes();
			send_transfer(vec, wgt, dot_model(vec, wgt));
		end
		end_burst();
		// pipeline fills the buffer, nothing may leave
		for (int i = 0; i < PIPE_LATENCY + 2; i++) begin
			@(negedge clk);
			assert (!in_credit) else begin
				$display("test %s got a credit while out_ready was low", test_name);
				fail_run();
			end
		end
		repeat (8) begin
			@(negedge clk);
			assert (out_valid && !in_credit) else begin
				$display("test %s lost out_valid or got a credit while stalled", test_name);
				fail_run();
			end
			assert (out_sum == exp_sum[pops_before]) else begin
				$display("ERROR %s: held sum expected %h, actual %h",
					test_name, exp_sum[pops_before], out_sum);
				fail_run();
			end
			assert (out_tag == exp_tag[pops_before]) else begin
				$display("ERROR %s: held tag expected %h, actual %h",
					test_name, exp_tag[pops_before], out_tag);
				fail_run();
			end
		end
		set_ready(1'b1);
		wait_idle();
	endtask

	initial begin
		reset     <= 1'b0;
		in_valid  <= 1'b0;
		in_vector <= '0;
		in_weight <= '0;
		in_tag    <= '0;
		out_ready <= 1'b0;
		wr_count      = 0;
		credits_spent = 0;
		next_tag      = '0;
		test_name     = "setup";
		void'($urandom(32'hb66a));
		test_reset_state();
		test_fixed_products();
		test_sign_handling();
		test_streaming();
		test_back_pressure();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
